/* norm_seq.f */
logic/norm_pkg.sv
logic/norm_ctrl.sv
logic/bit_counter.sv
logic/norm_front.sv
logic/frac_divider.sv
logic/norm_seq.sv
sim/norm_seq_assert.sv
sim/norm_seq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the norm_seq testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert \
	--top-module norm_seq_tb \
	--Mdir "$BUILD" -o norm_seq_sim \
	-f norm_seq.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

"./$BUILD/norm_seq_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "Simulation reported a failure."
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status."
	exit 1
fi

echo "Simulation passed."
exit 0

/* sim/norm_seq_tb.sv */
`timescale 1ns/1ps

module norm_seq_tb;

	import norm_pkg::*;

	localparam int          TIMEOUT_CYCLES = 40;
	localparam int          LATENCY        = 11; // Edges from accepted nd to valid.
	localparam int          RANDOM_PAIRS   = 200;
	localparam int unsigned SEED           = 32'h8069_327d;

	logic         clk;
	logic         rst;
	logic         nd;
	sample_pair_t din;
	logic         busy;
	logic         valid;
	frac_pair_t   dout;

	norm_seq i_norm_seq
	(
		.clk   (clk),
		.rst   (rst),
		.nd    (nd),
		.din   (din),
		.busy  (busy),
		.valid (valid),
		.dout  (dout)
	);

	bind norm_seq norm_seq_assert i_norm_seq_assert
	(
		.clk   (clk),
		.rst   (rst),
		.nd    (nd),
		.busy  (busy),
		.valid (valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// Reference model
	// ------------------------------

	function automatic int sample_abs(input int s);
		return (s < 0) ? -s : s;
	endfunction

	// Floor of mag * 256 / (mag + other + 1).
	function automatic int model_frac(input int mag, input int other);
		return (mag << FRAC_W) / (mag + other + 1);
	endfunction

	function automatic sample_pair_t random_pair();
		logic [31:0] r;
		r = $urandom;
		return r;
	endfunction

	// ------------------------------
	// Checking and waiting
	// ------------------------------

	task automatic check_value(input string what, input int got, input int expected);
		if (got != expected)
		begin
			$display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
			$display("CHECKS FAILED");
			$fatal(1, "Stopped at first error.");
		end
	endtask

	task automatic report_failure(input string reason);
		$display("Failure at %0t ns: %s", $time, reason);
		$display("CHECKS FAILED");
		$fatal(1, "Stopped at first error.");
	endtask

	// Counts falling edges after the accepting edge until valid.
	task automatic wait_valid(output int edges);
		logic seen;
		seen  = 1'b0;
		edges = 0;
		while (!seen && edges < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			edges++;
			check_value("busy while running", int'(busy), 1);
			seen = valid;
		end
		if (!seen)
		begin
			report_failure("valid never came after nd, timed out.");
		end
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			cycles++;
		end
		if (busy)
		begin
			report_failure("busy never dropped, timed out.");
		end
	endtask

	// One-cycle nd followed by a scrambled din so only the captured pair counts.
	task automatic start_pair(input sample_pair_t p);
		@(posedge clk);
		nd  <= 1'b1;
		din <= p;
		@(posedge clk);
		nd  <= 1'b0;
		din <= random_pair();
	endtask

	// Runs one pair and returns dout as seen with valid.
	task automatic measure_pair(input int a, input int b, output frac_pair_t res);
		sample_pair_t p;
		int           edges;
		p.din_1 = a[SAMPLE_W-1:0];
		p.din_2 = b[SAMPLE_W-1:0];
		start_pair(p);
		wait_valid(edges);
		check_value($sformatf("latency for (%0d,%0d)", a, b), edges, LATENCY);
		res = dout;
		wait_idle();
	endtask

	task automatic run_pair(input int a, input int b, output frac_pair_t res);
		int m1;
		int m2;
		m1 = sample_abs(a);
		m2 = sample_abs(b);
		measure_pair(a, b, res);
		check_value($sformatf("q_1 for (%0d,%0d)", a, b), int'(res.q_1), model_frac(m1, m2));
		check_value($sformatf("q_2 for (%0d,%0d)", a, b), int'(res.q_2), model_frac(m2, m1));
	endtask

	// ------------------------------
	// Tests
	// ------------------------------

	task automatic test_reset();
		@(negedge clk);
		check_value("busy after reset", int'(busy), 0);
		check_value("valid after reset", int'(valid), 0);
		check_value("dout after reset", int'(dout), 0);
	endtask

	task automatic test_corners();
		frac_pair_t res;
		run_pair(0, 0, res);
		run_pair(1, 0, res);
		run_pair(-1, 1, res);
		run_pair(32767, 32767, res);
		run_pair(-32768, 0, res);
		run_pair(-32768, -32768, res);
		run_pair(100, -300, res);
	endtask

	task automatic test_sign();
		int         a [4] = '{1234, -32767, 0, 20000};
		int         b [4] = '{-567, 12, -5, 20000};
		frac_pair_t pos;
		frac_pair_t neg;
		for (int i = 0; i < 4; i++)
		begin
			run_pair(a[i], b[i], pos);
			measure_pair(-a[i], -b[i], neg);
			check_value("negated pair q_1", int'(neg.q_1), int'(pos.q_1));
			check_value("negated pair q_2", int'(neg.q_2), int'(pos.q_2));
		end
	endtask

	task automatic test_nd_while_busy();
		sample_pair_t first;
		sample_pair_t second;
		frac_pair_t   res;
		int           valid_count;
		int           first_edge;
		first.din_1  = 16'sd5000;
		first.din_2  = -16'sd3000;
		second.din_1 = 16'sd100;
		second.din_2 = 16'sd0;
		valid_count  = 0;
		first_edge   = 0;
		res          = '0;
		start_pair(first);
		for (int i = 1; i <= 30; i++)
		begin
			@(negedge clk);
			if (valid)
			begin
				valid_count++;
				if (first_edge == 0)
				begin
					first_edge = i;
					res        = dout;
				end
			end
			if (i == 3) // Mid divide.
			begin
				@(posedge clk);
				nd  <= 1'b1;
				din <= second;
			end
			if (i == 4)
			begin
				@(posedge clk);
				nd <= 1'b0;
			end
		end
		check_value("valid pulses with nd while busy", valid_count, 1);
		check_value("latency with nd while busy", first_edge, LATENCY);
		check_value("q_1 with nd while busy", int'(res.q_1), model_frac(5000, 3000));
		check_value("q_2 with nd while busy", int'(res.q_2), model_frac(3000, 5000));
		check_value("busy after ignored nd", int'(busy), 0);
	endtask

	task automatic test_random();
		logic [31:0] r;
		frac_pair_t  res;
		for (int i = 0; i < RANDOM_PAIRS; i++)
		begin
			r = $urandom;
			run_pair(int'($signed(r[15:0])), int'($signed(r[31:16])), res);
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial
	begin
		rst = 1'b0;
		nd  = 1'b0;
		din = '0;
		void'($urandom(SEED));
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		test_reset();
		test_corners();
		test_sign();
		test_nd_while_busy();
		test_random();
		repeat (2) @(negedge clk);
		if (i_norm_seq.i_norm_seq_assert.fail_count != 0)
		begin
			$display("Assertion failures: %0d", i_norm_seq.i_norm_seq_assert.fail_count);
			$display("CHECKS FAILED");
			$fatal(1, "Assertions failed.");
		end
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

/* sim/norm_seq_assert.sv */
`timescale 1ns/1ps

module norm_seq_assert
(
	input logic clk,
	input logic rst,
	input logic nd,
	input logic busy,
	input logic valid
);

	int fail_count = 0;

	// ------------------------------
	// Output pulse timing
	// ------------------------------

	valid_one_cycle: assert property (@(posedge clk) disable iff (!rst) valid |=> !valid)
	else
	begin
		$error("valid stayed high for more than one cycle");
		fail_count = fail_count + 1;
	end

	// Accepted nd means IDLE, so busy is still low.
	valid_latency: assert property (@(posedge clk) disable iff (!rst) (nd && !busy) |-> ##11 valid)
	else
	begin
		$error("valid did not follow an accepted nd after 11 edges");
		fail_count = fail_count + 1;
	end

	// ------------------------------
	// Reset state
	// ------------------------------

	idle_after_reset: assert property (@(posedge clk) !rst |=> (!busy && !valid))
	else
	begin
		$error("busy or valid high after reset");
		fail_count = fail_count + 1;
	end

endmodule

/* logic/norm_seq.sv */
`timescale 1ns/1ps

module norm_seq
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   nd,
	input  norm_pkg::sample_pair_t din,
	output logic                   busy,
	output logic                   valid,
	output norm_pkg::frac_pair_t   dout
);

	import norm_pkg::*;

	logic                capture;
	logic                sum_en;
	logic                cnt_clear;
	logic                cnt_en;
	logic                last;
	div_ctrl_t           div;
	logic [SAMPLE_W-1:0] mag_1;
	logic [SAMPLE_W-1:0] mag_2;
	logic [DENOM_W-1:0]  denom;
	logic [FRAC_W-1:0]   quot_1;
	logic [FRAC_W-1:0]   quot_2;

	// ------------------------------
	// Control
	// ------------------------------

	norm_ctrl i_norm_ctrl
	(
		.clk       (clk),
		.rst       (rst),
		.nd        (nd),
		.last      (last),
		.capture   (capture),
		.sum_en    (sum_en),
		.cnt_clear (cnt_clear),
		.cnt_en    (cnt_en),
		.div       (div),
		.busy      (busy),
		.valid     (valid)
	);

	bit_counter i_bit_counter
	(
		.clk   (clk),
		.rst   (rst),
		.clear (cnt_clear),
		.en    (cnt_en),
		.last  (last)
	);

	// ------------------------------
	// Datapath
	// ------------------------------

	norm_front i_norm_front
	(
		.clk     (clk),
		.rst     (rst),
		.capture (capture),
		.sum_en  (sum_en),
		.din     (din),
		.mag_1   (mag_1),
		.mag_2   (mag_2),
		.denom   (denom)
	);

	// Both dividers share one denominator.
	frac_divider i_frac_div_1
	(
		.clk   (clk),
		.rst   (rst),
		.div   (div),
		.mag   (mag_1),
		.denom (denom),
		.quot  (quot_1)
	);

	frac_divider i_frac_div_2
	(
		.clk   (clk),
		.rst   (rst),
		.div   (div),
		.mag   (mag_2),
		.denom (denom),
		.quot  (quot_2)
	);

	assign dout.q_1 = quot_1;
	assign dout.q_2 = quot_2;

endmodule

/* logic/frac_divider.sv */
`timescale 1ns/1ps

module frac_divider
(
	input  logic                           clk,
	input  logic                           rst,
	input  norm_pkg::div_ctrl_t            div,
	input  logic [norm_pkg::SAMPLE_W-1:0] mag,
	input  logic [norm_pkg::DENOM_W-1:0]  denom,
	output logic [norm_pkg::FRAC_W-1:0]   quot
);

	import norm_pkg::*;

	logic [DENOM_W-1:0] divisor;
	logic [DENOM_W:0]   rem;     // One spare bit for the doubling.
	logic [DENOM_W:0]   rem_dbl;
	logic [DENOM_W:0]   rem_sub;
	logic               fits;

	// ------------------------------
	// Trial subtraction
	// ------------------------------

	// Remainder stays below the divisor, so the top bit of rem is zero.
	assign rem_dbl = {rem[DENOM_W-1:0], 1'b0};
	assign fits    = (rem_dbl >= {1'b0, divisor});
	assign rem_sub = rem_dbl - {1'b0, divisor};

	// ------------------------------
	// Divisor and remainder
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (div.load)
		begin
			divisor <= denom;
			rem     <= (DENOM_W + 1)'(mag);
		end
		else if (div.step)
		begin
			if (fits)
			begin
				rem <= rem_sub;
			end
			else
			begin
				rem <= rem_dbl;
			end
		end
	end

	// ------------------------------
	// Quotient
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			quot <= '0;
		end
		else if (div.load)
		begin
			quot <= '0;
		end
		else if (div.step)
		begin
			quot <= {quot[FRAC_W-2:0], fits}; // MSB first.
		end
	end

endmodule

/* logic/norm_front.sv */
`timescale 1ns/1ps

module norm_front
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           capture,
	input  logic                           sum_en,
	input  norm_pkg::sample_pair_t         din,
	output logic [norm_pkg::SAMPLE_W-1:0] mag_1,
	output logic [norm_pkg::SAMPLE_W-1:0] mag_2,
	output logic [norm_pkg::DENOM_W-1:0]  denom
);

	import norm_pkg::*;

	sample_pair_t         smp;
	logic [SAMPLE_W-1:0] abs_1;
	logic [SAMPLE_W-1:0] abs_2;
	logic [DENOM_W-1:0]  denom_next;

	// Two's complement magnitude, -32768 maps to 32768 unsigned.
	function automatic logic [SAMPLE_W-1:0] magnitude(input logic signed [SAMPLE_W-1:0] x);
		logic [SAMPLE_W-1:0] u;
		u = x;
		if (u[SAMPLE_W-1])
		begin
			return ~u + 1'b1;
		end
		else
		begin
			return u;
		end
	endfunction

	// ------------------------------
	// Input capture
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			smp <= din;
		end
	end

	// ------------------------------
	// Magnitudes and denominator
	// ------------------------------

	assign abs_1      = magnitude(smp.din_1);
	assign abs_2      = magnitude(smp.din_2);
	assign denom_next = DENOM_W'(abs_1) + DENOM_W'(abs_2) + DENOM_W'(1); // Never zero.

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			mag_1 <= '0;
			mag_2 <= '0;
			denom <= DENOM_W'(1);
		end
		else if (sum_en)
		begin
			mag_1 <= abs_1;
			mag_2 <= abs_2;
			denom <= denom_next;
		end
	end

endmodule

/* logic/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter
(
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic en,
	output logic last
);

	import norm_pkg::*;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;
		end
		else if (en)
		begin
			count <= count + 1'b1;
		end
	end

	// High during the final divide step.
	assign last = (count == CNT_W'(FRAC_W - 1));

endmodule

/* logic/norm_ctrl.sv */
`timescale 1ns/1ps

module norm_ctrl
(
	input  logic                clk,
	input  logic                rst,
	input  logic                nd,
	input  logic                last,
	output logic                capture,
	output logic                sum_en,
	output logic                cnt_clear,
	output logic                cnt_en,
	output norm_pkg::div_ctrl_t div,
	output logic                busy,
	output logic                valid
);

	import norm_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	// ------------------------------
	// State register
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	// ------------------------------
	// Next state
	// ------------------------------

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (nd) // New pair only accepted here.
				begin
					state_next = SUM;
				end
			end
			SUM:
			begin
				state_next = LOAD;
			end
			LOAD:
			begin
				state_next = DIVIDE;
			end
			DIVIDE:
			begin
				if (last)
				begin
					state_next = DONE;
				end
			end
			DONE:
			begin
				state_next = IDLE;
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	// ------------------------------
	// Stage strobes
	// ------------------------------

	always_comb
	begin
		capture   = (state == IDLE) && nd;
		sum_en    = (state == SUM);
		cnt_clear = (state == LOAD);
		cnt_en    = (state == DIVIDE);
		div.load  = (state == LOAD);
		div.step  = (state == DIVIDE); // One quotient bit per cycle.
	end

	assign busy  = (state != IDLE);
	assign valid = (state == DONE); // Single cycle, DONE always exits.

endmodule

/* logic/norm_pkg.sv */
package norm_pkg;

	// ------------------------------
	// Widths
	// ------------------------------

	localparam int SAMPLE_W = 16; // Signed input samples.
	localparam int DENOM_W  = 17; // Sum of magnitudes plus one.
	localparam int FRAC_W   = 8;  // Also the number of divide steps.
	localparam int CNT_W    = 4;

	// ------------------------------
	// Data types
	// ------------------------------

	typedef struct packed
	{
		logic signed [SAMPLE_W-1:0] din_1;
		logic signed [SAMPLE_W-1:0] din_2;
	} sample_pair_t;

	typedef struct packed
	{
		logic [FRAC_W-1:0] q_1;
		logic [FRAC_W-1:0] q_2;
	} frac_pair_t;

	// Controller states.
	typedef enum logic [2:0]
	{
		IDLE   = 3'd0,
		SUM    = 3'd1,
		LOAD   = 3'd2,
		DIVIDE = 3'd3,
		DONE   = 3'd4
	} ctrl_state_t;

	// Strobes shared by both dividers.
	typedef struct packed
	{
		logic load;
		logic step;
	} div_ctrl_t;

endpackage
